// ==== include/rvd_defines.svh ====
// Build-time parameters for the decode stage
// Data width, M-extension switch and boot program counter

`ifndef RVD_DEFINES_SVH
`define RVD_DEFINES_SVH

////////////////////////////////////////
// Datapath
////////////////////////////////////////

// Width of instruction words, addresses and immediates
`define RVD_XLEN 32

// Set to 1 to decode MUL/DIV, 0 to flag them as illegal
`define RVD_M_EXT 1

// Program counter reported by the fetch buffer out of reset
`define RVD_PC_RESET 32'h0000_0080

`endif

// ==== rtl/rvd_pkg.sv ====
// Shared types of the decode stage
// Major opcodes, ALU operations, CSR operations and system operations

package rvd_pkg;

  // RV32 major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b000_0011,
    OPC_MISC_MEM = 7'b000_1111,
    OPC_OP_IMM   = 7'b001_0011,
    OPC_AUIPC    = 7'b001_0111,
    OPC_STORE    = 7'b010_0011,
    OPC_OP       = 7'b011_0011,
    OPC_LUI      = 7'b011_0111,
    OPC_BRANCH   = 7'b110_0011,
    OPC_JALR     = 7'b110_0111,
    OPC_JAL      = 7'b110_1111,
    OPC_SYSTEM   = 7'b111_0011
  } opcode_e;

  // ALU operations where PASS_B forwards operand B for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  // CSR access kinds with READ as the neutral value
  typedef enum logic [1:0] {
    CSR_OP_READ,
    CSR_OP_WRITE,
    CSR_OP_SET,
    CSR_OP_CLEAR
  } csr_op_e;

  // System instructions that the controller acts upon
  typedef enum logic [2:0] {
    SYS_NONE,
    SYS_ECALL,
    SYS_EBREAK,
    SYS_MRET,
    SYS_DRET,
    SYS_WFI,
    SYS_FENCEI
  } sys_op_e;

endpackage

// ==== rtl/decode_bus_if.sv ====
// Decode bus between the instruction decoder and the ID/EX register
// Unit enables, operation selects, register fields and immediate

`timescale 1ns/1ps
`include "rvd_defines.svh"

interface decode_bus_if;
  import rvd_pkg::*;

  // One-hot functional unit select
  logic                 alu_en;
  logic                 mul_en;
  logic                 div_en;
  logic                 csr_en;
  logic                 sys_en;
  logic                 lsu_en;

  // Write-back request and illegal flag
  logic                 rf_we;
  logic                 illegal;

  // Operation selects for the enabled unit
  alu_op_e              alu_op;
  csr_op_e              csr_op;
  sys_op_e              sys_op;

  // Register fields and immediate
  logic [4:0]           rd;
  logic [4:0]           rs1;
  logic [4:0]           rs2;
  logic [`RVD_XLEN-1:0] imm;

  modport master (
    output alu_en, mul_en, div_en, csr_en, sys_en, lsu_en,
    output rf_we, illegal, alu_op, csr_op, sys_op, rd, rs1, rs2, imm
  );

  modport slave (
    input alu_en, mul_en, div_en, csr_en, sys_en, lsu_en,
    input rf_we, illegal, alu_op, csr_op, sys_op, rd, rs1, rs2, imm
  );

endinterface

// ==== rtl/fetch_buffer.sv ====
// One-entry fetch buffer in front of the decoder
// Holds an instruction word and its PC until decode takes it

`timescale 1ns/1ps
`include "rvd_defines.svh"

module fetch_buffer (
  input  logic                 clk,
  input  logic                 arst_n_i,

  // Fetch side
  input  logic                 instr_valid_i,
  input  logic [`RVD_XLEN-1:0] instr_i,
  input  logic [`RVD_XLEN-1:0] pc_i,
  output logic                 instr_ready_o,

  // Decode side
  input  logic                 id_ready_i,
  output logic                 buf_valid_o,
  output logic [`RVD_XLEN-1:0] buf_instr_o,
  output logic [`RVD_XLEN-1:0] buf_pc_o
);

  logic                 valid_q;
  logic [`RVD_XLEN-1:0] instr_q;
  logic [`RVD_XLEN-1:0] pc_q;
  logic                 accept;

  // An empty slot can always take a word, a full one only when decode
  // frees it in the same cycle
  assign instr_ready_o = !valid_q || id_ready_i;
  assign accept        = instr_valid_i && instr_ready_o;

  ////////////////////////////////////////
  // Occupancy flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      // Decode took the word (or a kill dropped it)
      valid_q <= 1'b0;
    end
  end

  // Program counter of the buffered word starts at the boot address
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= `RVD_PC_RESET;
    end else if (accept) begin
      pc_q <= pc_i;
    end
  end

  // Instruction word only changes on an accepted transfer
  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= instr_i;
    end
  end

  assign buf_valid_o = valid_q;
  assign buf_instr_o = instr_q;
  assign buf_pc_o    = pc_q;

endmodule

// ==== rtl/instr_decoder.sv ====
// Combinational RV32I/M instruction decoder
// Unit select, operation selects, immediates and illegal detection

`timescale 1ns/1ps
`include "rvd_defines.svh"

module instr_decoder (
  input  logic                 buf_valid_i,
  input  logic [`RVD_XLEN-1:0] buf_instr_i,
  decode_bus_if.master         dec
);
  import rvd_pkg::*;

  opcode_e              opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`RVD_XLEN-1:0] imm_i;
  logic [`RVD_XLEN-1:0] imm_s;
  logic [`RVD_XLEN-1:0] imm_b;
  logic [`RVD_XLEN-1:0] imm_u;
  logic [`RVD_XLEN-1:0] imm_j;
  logic                 illegal;
  logic                 writes_rd;

  // Register-register and register-immediate ALU operations share funct3
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = opcode_e'(buf_instr_i[6:0]);
  assign funct3 = buf_instr_i[14:12];
  assign funct7 = buf_instr_i[31:25];

  // Register fields pass through untouched, execute ignores unused ones
  assign dec.rd  = buf_instr_i[11:7];
  assign dec.rs1 = buf_instr_i[19:15];
  assign dec.rs2 = buf_instr_i[24:20];

  ////////////////////////////////////////
  // Immediate formats
  ////////////////////////////////////////

  assign imm_i = {{20{buf_instr_i[31]}}, buf_instr_i[31:20]};
  assign imm_s = {{20{buf_instr_i[31]}}, buf_instr_i[31:25], buf_instr_i[11:7]};
  assign imm_b = {{19{buf_instr_i[31]}}, buf_instr_i[31], buf_instr_i[7],
                  buf_instr_i[30:25], buf_instr_i[11:8], 1'b0};
  assign imm_u = {buf_instr_i[31:12], 12'b0};
  assign imm_j = {{11{buf_instr_i[31]}}, buf_instr_i[31], buf_instr_i[19:12],
                  buf_instr_i[20], buf_instr_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////

  always_comb begin
    illegal    = 1'b0;
    writes_rd  = 1'b0;
    dec.alu_en = 1'b0;
    dec.mul_en = 1'b0;
    dec.div_en = 1'b0;
    dec.csr_en = 1'b0;
    dec.sys_en = 1'b0;
    dec.lsu_en = 1'b0;
    dec.alu_op = ALU_ADD;
    dec.csr_op = CSR_OP_READ;
    dec.sys_op = SYS_NONE;
    dec.imm    = imm_i;

    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b000_0001) begin
          // In the M extension funct3[2] separates DIV/REM from MUL
          if (`RVD_M_EXT != 0) begin
            dec.mul_en = !funct3[2];
            dec.div_en = funct3[2];
            // The variant in funct3 reaches the unit through the ALU select
            dec.alu_op = alu_from_funct3(funct3, 1'b0);
            writes_rd  = 1'b1;
          end else begin
            illegal = 1'b1;
          end
        end else if (funct7 == 7'b000_0000 ||
                     (funct7 == 7'b010_0000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.alu_en = 1'b1;
          dec.alu_op = alu_from_funct3(funct3, funct7[5]);
          writes_rd  = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        // Shift amounts live in rs2, so funct7 is checked for shifts only
        if ((funct3 == 3'b001 && funct7 != 7'b000_0000) ||
            (funct3 == 3'b101 && funct7 != 7'b000_0000 && funct7 != 7'b010_0000)) begin
          illegal = 1'b1;
        end else begin
          dec.alu_en = 1'b1;
          dec.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && funct7[5]);
          writes_rd  = 1'b1;
        end
      end
      OPC_LOAD: begin
        // LB, LH, LW, LBU, LHU
        illegal    = (funct3 == 3'b011) || funct3[2:1] == 2'b11;
        dec.lsu_en = 1'b1;
        writes_rd  = 1'b1;
      end
      OPC_STORE: begin
        illegal    = funct3[2] || funct3 == 3'b011;
        dec.lsu_en = 1'b1;
        dec.imm    = imm_s;
      end
      OPC_BRANCH: begin
        // Equality uses a subtract, the ordered compares use SLT/SLTU
        illegal    = funct3[2:1] == 2'b01;
        dec.alu_en = 1'b1;
        dec.imm    = imm_b;
        case (funct3[2:1])
          2'b10:   dec.alu_op = ALU_SLT;
          2'b11:   dec.alu_op = ALU_SLTU;
          default: dec.alu_op = ALU_SUB;
        endcase
      end
      OPC_LUI: begin
        dec.alu_en = 1'b1;
        dec.alu_op = ALU_PASS_B;
        dec.imm    = imm_u;
        writes_rd  = 1'b1;
      end
      OPC_AUIPC: begin
        dec.alu_en = 1'b1;
        dec.imm    = imm_u;
        writes_rd  = 1'b1;
      end
      OPC_JAL: begin
        dec.alu_en = 1'b1;
        dec.imm    = imm_j;
        writes_rd  = 1'b1;
      end
      OPC_JALR: begin
        illegal    = funct3 != 3'b000;
        dec.alu_en = 1'b1;
        writes_rd  = 1'b1;
      end
      OPC_MISC_MEM: begin
        // FENCE needs no action in an in-order core, FENCE.I flushes fetch
        illegal    = funct3[2:1] != 2'b00;
        dec.sys_en = 1'b1;
        dec.sys_op = funct3[0] ? SYS_FENCEI : SYS_NONE;
      end
      OPC_SYSTEM: begin
        if (funct3 == 3'b000) begin
          dec.sys_en = 1'b1;
          illegal    = (dec.rs1 != 5'd0) || (dec.rd != 5'd0);
          case (buf_instr_i[31:20])
            12'h000: dec.sys_op = SYS_ECALL;
            12'h001: dec.sys_op = SYS_EBREAK;
            12'h302: dec.sys_op = SYS_MRET;
            12'h7b2: dec.sys_op = SYS_DRET;
            12'h105: dec.sys_op = SYS_WFI;
            default: illegal = 1'b1;
          endcase
        end else if (funct3 == 3'b100) begin
          illegal = 1'b1;
        end else begin
          // CSR address travels in the immediate, rs1 holds the register or uimm
          dec.csr_en = 1'b1;
          dec.imm    = {20'b0, buf_instr_i[31:20]};
          writes_rd  = 1'b1;
          // Set and clear with a zero source only read the CSR
          if (funct3[1:0] == 2'b01) begin
            dec.csr_op = CSR_OP_WRITE;
          end else if (dec.rs1 != 5'd0) begin
            dec.csr_op = funct3[0] ? CSR_OP_CLEAR : CSR_OP_SET;
          end
        end
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // An illegal or absent instruction must not touch any unit
    if (illegal || !buf_valid_i) begin
      dec.alu_en = 1'b0;
      dec.mul_en = 1'b0;
      dec.div_en = 1'b0;
      dec.csr_en = 1'b0;
      dec.sys_en = 1'b0;
      dec.lsu_en = 1'b0;
      dec.csr_op = CSR_OP_READ;
      dec.sys_op = SYS_NONE;
    end
    dec.illegal = illegal || !buf_valid_i;
    dec.rf_we   = writes_rd && (dec.rd != 5'd0) && !dec.illegal;
  end

endmodule

// ==== rtl/id_ex_register.sv ====
// ID/EX pipeline register with halt, kill and execute back-pressure
// Produces the decode handshake and holds one decoded instruction

`timescale 1ns/1ps
`include "rvd_defines.svh"

module id_ex_register (
  input  logic                 clk,
  input  logic                 arst_n_i,

  // Decode side
  input  logic                 buf_valid_i,
  input  logic [`RVD_XLEN-1:0] buf_pc_i,
  decode_bus_if.slave          dec,

  // Controller
  input  logic                 halt_i,
  input  logic                 kill_i,

  // Execute side
  input  logic                 ex_ready_i,
  output logic                 id_ready_o,
  output logic                 ex_valid_o,
  output logic [`RVD_XLEN-1:0] ex_pc_o,
  output logic                 ex_alu_en_o,
  output logic                 ex_mul_en_o,
  output logic                 ex_div_en_o,
  output logic                 ex_csr_en_o,
  output logic                 ex_sys_en_o,
  output logic                 ex_lsu_en_o,
  output logic                 ex_rf_we_o,
  output logic                 ex_illegal_o,
  output rvd_pkg::alu_op_e     ex_alu_op_o,
  output rvd_pkg::csr_op_e     ex_csr_op_o,
  output rvd_pkg::sys_op_e     ex_sys_op_o,
  output logic [4:0]           ex_rd_o,
  output logic [4:0]           ex_rs1_o,
  output logic [4:0]           ex_rs2_o,
  output logic [`RVD_XLEN-1:0] ex_imm_o
);

  logic stall;
  logic id_valid;

  // Execute holds a result it has not accepted yet
  assign stall = ex_valid_o && !ex_ready_i;

  // Kill drains the buffer, halt and stall freeze it
  assign id_ready_o = kill_i || (!halt_i && !stall);
  assign id_valid   = buf_valid_i && !kill_i && !halt_i && !stall;

  ////////////////////////////////////////
  // Control state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex_valid_o   <= 1'b0;
      ex_alu_en_o  <= 1'b0;
      ex_mul_en_o  <= 1'b0;
      ex_div_en_o  <= 1'b0;
      ex_csr_en_o  <= 1'b0;
      ex_sys_en_o  <= 1'b0;
      ex_lsu_en_o  <= 1'b0;
      ex_rf_we_o   <= 1'b0;
      ex_illegal_o <= 1'b0;
    end else if (id_valid) begin
      ex_valid_o   <= 1'b1;
      ex_alu_en_o  <= dec.alu_en;
      ex_mul_en_o  <= dec.mul_en;
      ex_div_en_o  <= dec.div_en;
      ex_csr_en_o  <= dec.csr_en;
      ex_sys_en_o  <= dec.sys_en;
      ex_lsu_en_o  <= dec.lsu_en;
      ex_rf_we_o   <= dec.rf_we;
      ex_illegal_o <= dec.illegal;
    end else if (!stall) begin
      // Slot was taken or stayed empty, so nothing may reach a unit
      ex_valid_o   <= 1'b0;
      ex_alu_en_o  <= 1'b0;
      ex_mul_en_o  <= 1'b0;
      ex_div_en_o  <= 1'b0;
      ex_csr_en_o  <= 1'b0;
      ex_sys_en_o  <= 1'b0;
      ex_lsu_en_o  <= 1'b0;
      ex_rf_we_o   <= 1'b0;
      ex_illegal_o <= 1'b0;
    end
  end

  // Payload fields load together with the control state
  always_ff @(posedge clk) begin
    if (id_valid) begin
      ex_pc_o     <= buf_pc_i;
      ex_alu_op_o <= dec.alu_op;
      ex_csr_op_o <= dec.csr_op;
      ex_sys_op_o <= dec.sys_op;
      ex_rd_o     <= dec.rd;
      ex_rs1_o    <= dec.rs1;
      ex_rs2_o    <= dec.rs2;
      ex_imm_o    <= dec.imm;
    end
  end

endmodule

// ==== rtl/id_stage_top.sv ====
// Top level of the instruction decode stage
// Fetch buffer, decoder and ID/EX register joined by the decode bus

`timescale 1ns/1ps
`include "rvd_defines.svh"

module id_stage_top (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 instr_valid_i,
  input  logic [`RVD_XLEN-1:0] instr_i,
  input  logic [`RVD_XLEN-1:0] pc_i,
  output logic                 instr_ready_o,
  input  logic                 halt_i,
  input  logic                 kill_i,
  input  logic                 ex_ready_i,
  output logic                 ex_valid_o,
  output logic [`RVD_XLEN-1:0] ex_pc_o,
  output logic                 ex_alu_en_o,
  output logic                 ex_mul_en_o,
  output logic                 ex_div_en_o,
  output logic                 ex_csr_en_o,
  output logic                 ex_sys_en_o,
  output logic                 ex_lsu_en_o,
  output logic                 ex_rf_we_o,
  output logic                 ex_illegal_o,
  output rvd_pkg::alu_op_e     ex_alu_op_o,
  output rvd_pkg::csr_op_e     ex_csr_op_o,
  output rvd_pkg::sys_op_e     ex_sys_op_o,
  output logic [4:0]           ex_rd_o,
  output logic [4:0]           ex_rs1_o,
  output logic [4:0]           ex_rs2_o,
  output logic [`RVD_XLEN-1:0] ex_imm_o
);

  // Buffered instruction and the decode handshake
  logic                 buf_valid;
  logic [`RVD_XLEN-1:0] buf_instr;
  logic [`RVD_XLEN-1:0] buf_pc;
  logic                 id_ready;

  decode_bus_if i_dec_bus ();

  fetch_buffer i_fetch_buffer (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .id_ready_i    (id_ready),
    .buf_valid_o   (buf_valid),
    .buf_instr_o   (buf_instr),
    .buf_pc_o      (buf_pc)
  );

  instr_decoder i_instr_decoder (
    .buf_valid_i (buf_valid),
    .buf_instr_i (buf_instr),
    .dec         (i_dec_bus.master)
  );

  id_ex_register i_id_ex_register (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .buf_valid_i  (buf_valid),
    .buf_pc_i     (buf_pc),
    .dec          (i_dec_bus.slave),
    .halt_i       (halt_i),
    .kill_i       (kill_i),
    .ex_ready_i   (ex_ready_i),
    .id_ready_o   (id_ready),
    .ex_valid_o   (ex_valid_o),
    .ex_pc_o      (ex_pc_o),
    .ex_alu_en_o  (ex_alu_en_o),
    .ex_mul_en_o  (ex_mul_en_o),
    .ex_div_en_o  (ex_div_en_o),
    .ex_csr_en_o  (ex_csr_en_o),
    .ex_sys_en_o  (ex_sys_en_o),
    .ex_lsu_en_o  (ex_lsu_en_o),
    .ex_rf_we_o   (ex_rf_we_o),
    .ex_illegal_o (ex_illegal_o),
    .ex_alu_op_o  (ex_alu_op_o),
    .ex_csr_op_o  (ex_csr_op_o),
    .ex_sys_op_o  (ex_sys_op_o),
    .ex_rd_o      (ex_rd_o),
    .ex_rs1_o     (ex_rs1_o),
    .ex_rs2_o     (ex_rs2_o),
    .ex_imm_o     (ex_imm_o)
  );

endmodule

// ==== verification/id_stage_checker.sv ====
// Checker for the decode stage, connected to the DUT ports
// Immediate assertions for ordered decode, illegal, one-hot, halt, kill and stall

`timescale 1ns/1ps
`include "rvd_defines.svh"

module id_stage_checker (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 instr_ready_o,
  input  logic                 halt_i,
  input  logic                 kill_i,
  input  logic                 ex_ready_i,
  input  logic                 ex_valid_o,
  input  logic [`RVD_XLEN-1:0] ex_pc_o,
  input  logic [5:0]           ex_en_i,
  input  logic                 ex_rf_we_o,
  input  logic                 ex_illegal_o,
  input  rvd_pkg::alu_op_e     ex_alu_op_o,
  input  rvd_pkg::csr_op_e     ex_csr_op_o,
  input  rvd_pkg::sys_op_e     ex_sys_op_o,
  input  logic [4:0]           ex_rd_o,
  input  logic [4:0]           ex_rs1_o,
  input  logic [4:0]           ex_rs2_o,
  input  logic [`RVD_XLEN-1:0] ex_imm_o,
  // Expectations from the reference model
  input  logic                 exp_ex_valid_i,
  input  logic                 exp_buf_full_i,
  input  logic [95:0]          exp_rec_i
);
  import rvd_pkg::*;

  logic [95:0] act;
  logic [95:0] act_cmp;
  logic [95:0] held;
  logic        stalled;

  // Counters per test in the order decode, illegal, one-hot, halt, kill and back-pressure
  int chk_cnt[6];
  int err_cnt[6];

  // Same field order as the model record
  assign act = {ex_en_i, ex_rf_we_o, ex_illegal_o, ex_alu_op_o, ex_csr_op_o, ex_sys_op_o,
                ex_rd_o, ex_rs1_o, ex_rs2_o, ex_imm_o, ex_pc_o};

  initial begin
    stalled = 1'b0;
    held    = '0;
    for (int i = 0; i < 6; i++) begin
      chk_cnt[i] = 0;
      err_cnt[i] = 0;
    end
  end

  ////////////////////////////////////////
  // Sampled on the rising edge
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (arst_n_i) begin
      // Occupancy of the ID/EX slot follows the model
      chk_cnt[0]++;
      assert (ex_valid_o == exp_ex_valid_i) else begin
        err_cnt[0]++;
        $display("Fail legal_decode ex_valid expected %0b actual %0b", exp_ex_valid_i, ex_valid_o);
      end
      // An empty slot drives no unit
      if (!ex_valid_o) begin
        chk_cnt[0]++;
        assert (act[95:88] == 8'd0) else begin
          err_cnt[0]++;
          $display("Fail legal_decode empty slot expected %h actual %h", 8'd0, act[95:88]);
        end
      end
      // The ALU select of an illegal word carries no meaning
      act_cmp = act;
      if (exp_rec_i[88]) act_cmp[87:84] = exp_rec_i[87:84];
      if (ex_valid_o && ex_ready_i) begin
        chk_cnt[0]++;
        assert (act_cmp == exp_rec_i) else begin
          err_cnt[0]++;
          $display("Fail legal_decode expected %h actual %h", exp_rec_i, act);
        end
      end
      if (ex_illegal_o) begin
        chk_cnt[1]++;
        assert (act[95:89] == 7'd0 && ex_sys_op_o == SYS_NONE && ex_csr_op_o == CSR_OP_READ)
        else begin
          err_cnt[1]++;
          $display("Fail illegal_clean expected %h actual %h", 12'h000,
                   {act[95:89], ex_csr_op_o, ex_sys_op_o});
        end
      end
      chk_cnt[2]++;
      assert ($countones(ex_en_i) <= 1) else begin
        err_cnt[2]++;
        $display("Fail one_hot expected at most one enable actual %b", ex_en_i);
      end
      if (halt_i && !kill_i && exp_buf_full_i) begin
        chk_cnt[3]++;
        assert (!instr_ready_o) else begin
          err_cnt[3]++;
          $display("Fail halt instr_ready expected 0 actual %0b", instr_ready_o);
        end
      end
      if (kill_i) begin
        chk_cnt[4]++;
        assert (instr_ready_o) else begin
          err_cnt[4]++;
          $display("Fail kill instr_ready expected 1 actual %0b", instr_ready_o);
        end
      end
      // A stalled result must not move before execute takes it
      if (stalled) begin
        chk_cnt[5]++;
        assert (act == held) else begin
          err_cnt[5]++;
          $display("Fail back_pressure expected %h actual %h", held, act);
        end
      end
      // Kill still frees the buffer while execute stalls
      if (ex_valid_o && !ex_ready_i && !kill_i && exp_buf_full_i) begin
        chk_cnt[5]++;
        assert (!instr_ready_o) else begin
          err_cnt[5]++;
          $display("Fail back_pressure instr_ready expected 0 actual %0b", instr_ready_o);
        end
      end
      stalled = ex_valid_o && !ex_ready_i;
      held    = act;
    end
  end

endmodule

// ==== verification/tb_id_stage.sv ====
// Testbench for the decode stage
// Clock, reset, random stimulus, reference decode model and reporting

`timescale 1ns/1ps
`include "rvd_defines.svh"

module tb_id_stage;
  import rvd_pkg::*;

  logic clk, arst_n_i, instr_valid_i, instr_ready_o, halt_i, kill_i, ex_ready_i, ex_valid_o;
  logic [31:0] instr_i, pc_i, ex_pc_o, ex_imm_o;
  logic ex_alu_en_o, ex_mul_en_o, ex_div_en_o, ex_csr_en_o, ex_sys_en_o, ex_lsu_en_o;
  logic ex_rf_we_o, ex_illegal_o;
  alu_op_e ex_alu_op_o;
  csr_op_e ex_csr_op_o;
  sys_op_e ex_sys_op_o;
  logic [4:0] ex_rd_o, ex_rs1_o, ex_rs2_o;

  // Model state of the fetch buffer, the ID/EX slot and the pending results
  logic [95:0] rec_q[$];
  logic [95:0] exp_rec;
  logic exp_ex_valid, exp_buf_full, mb_valid, mex_valid, m_stall, m_idr, m_idv, m_accept;
  logic [31:0] mb_instr, mb_pc, rng, next_pc, ra, rb;
  bit timed_out;
  int total_chk, total_err;
  string names[6];

  id_stage_top i_id_stage_top (.*);

  id_stage_checker i_id_stage_checker (
    .ex_en_i ({ex_alu_en_o, ex_mul_en_o, ex_div_en_o, ex_csr_en_o, ex_sys_en_o, ex_lsu_en_o}),
    .exp_ex_valid_i (exp_ex_valid), .exp_buf_full_i (exp_buf_full), .exp_rec_i (exp_rec), .*
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  ////////////////////////////////////////
  // Stimulus and reference decode
  ////////////////////////////////////////

  // The group comes from b[3:0] and values 12 to 15 leave a raw random word
  function automatic logic [31:0] make_instr(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] w;
    logic [2:0]  f3;
    w  = a;
    f3 = b[6:4];
    case (b[3:0])
      4'd0: begin
        w[6:0] = 7'h33;
        if (b[8:7] == 2'd0) w[31:25] = 7'h01;
        else if (b[8:7] == 2'd1 && (f3 == 3'd0 || f3 == 3'd5)) w[31:25] = 7'h20;
        else w[31:25] = 7'h00;
      end
      4'd1: begin
        w[6:0] = 7'h13;
        if (f3 == 3'd1) w[31:25] = 7'h00;
        if (f3 == 3'd5) w[31:25] = b[7] ? 7'h20 : 7'h00;
      end
      4'd2: begin
        w[6:0] = 7'h03;
        if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;
      end
      4'd3: begin
        w[6:0] = 7'h23;
        f3 = (b[8:7] == 2'd3) ? 3'd2 : {1'b0, b[8:7]};
      end
      4'd4: begin
        w[6:0] = 7'h63;
        if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;
      end
      4'd5: w[6:0] = 7'h37;
      4'd6: w[6:0] = 7'h17;
      4'd7: w[6:0] = 7'h6f;
      4'd8: begin
        w[6:0] = 7'h67;
        f3 = 3'd0;
      end
      4'd9: begin
        w[6:0] = 7'h0f;
        f3 = {2'b00, b[7]};
      end
      4'd10: begin
        w[6:0] = 7'h73;
        f3 = 3'd0;
        w[11:7] = 5'd0;
        w[19:15] = 5'd0;
        case (b[9:7])
          3'd0: w[31:20] = 12'h000;
          3'd1: w[31:20] = 12'h001;
          3'd2: w[31:20] = 12'h302;
          3'd3: w[31:20] = 12'h7b2;
          default: w[31:20] = 12'h105;
        endcase
      end
      4'd11: begin
        w[6:0] = 7'h73;
        if (f3 == 3'd0 || f3 == 3'd4) f3 = 3'd1;
      end
      default: return a;
    endcase
    // U and J formats keep bits 14:12 as immediate
    if (b[3:0] != 4'd5 && b[3:0] != 4'd6 && b[3:0] != 4'd7) w[14:12] = f3;
    return w;
  endfunction

  // Record fields from the top are enables, rf_we, illegal, alu_op, csr_op, sys_op,
  // rd, rs1, rs2, imm and pc
  function automatic logic [95:0] ref_decode(input logic [31:0] w, input logic [31:0] pc);
    logic [5:0]  en;
    logic        wr, ill;
    logic [3:0]  aop;
    logic [1:0]  cop;
    logic [2:0]  sop;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [6:0]  f7;
    f3 = w[14:12];
    f7 = w[31:25];
    en = 6'd0;
    wr = 1'b0;
    ill = 1'b0;
    aop = ALU_ADD;
    cop = CSR_OP_READ;
    sop = SYS_NONE;
    imm = {{20{w[31]}}, w[31:20]};
    case (w[6:0])
      7'h33, 7'h13: begin
        case (f3)
          3'd0: aop = ALU_ADD;
          3'd1: aop = ALU_SLL;
          3'd2: aop = ALU_SLT;
          3'd3: aop = ALU_SLTU;
          3'd4: aop = ALU_XOR;
          3'd5: aop = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
          3'd6: aop = ALU_OR;
          default: aop = ALU_AND;
        endcase
        if (w[6:0] == 7'h33 && f7 == 7'h01) begin
          ill = (`RVD_M_EXT == 0);
          en = f3[2] ? 6'b001000 : 6'b010000;
        end else if (w[6:0] == 7'h33) begin
          ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
          if (f3 == 3'd0 && f7 == 7'h20) aop = ALU_SUB;
          en = 6'b100000;
        end else begin
          ill = (f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
          en = 6'b100000;
        end
        wr = 1'b1;
      end
      7'h03: begin
        ill = (f3 == 3'd3) || (f3 >= 3'd6);
        en = 6'b000001;
        wr = 1'b1;
      end
      7'h23: begin
        ill = (f3 > 3'd2);
        en = 6'b000001;
        imm = {{20{w[31]}}, w[31:25], w[11:7]};
      end
      7'h63: begin
        ill = (f3 == 3'd2) || (f3 == 3'd3);
        en = 6'b100000;
        aop = (f3 >= 3'd6) ? ALU_SLTU : (f3 >= 3'd4) ? ALU_SLT : ALU_SUB;
        imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      7'h37, 7'h17: begin
        en = 6'b100000;
        aop = (w[6:0] == 7'h37) ? ALU_PASS_B : ALU_ADD;
        imm = {w[31:12], 12'd0};
        wr = 1'b1;
      end
      7'h6f: begin
        en = 6'b100000;
        imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        wr = 1'b1;
      end
      7'h67: begin
        ill = (f3 != 3'd0);
        en = 6'b100000;
        wr = 1'b1;
      end
      7'h0f: begin
        ill = (f3 > 3'd1);
        en = 6'b000010;
        sop = (f3 == 3'd1) ? SYS_FENCEI : SYS_NONE;
      end
      7'h73: begin
        if (f3 == 3'd0) begin
          en = 6'b000010;
          ill = (w[19:15] != 5'd0) || (w[11:7] != 5'd0);
          if (w[31:20] == 12'h000) sop = SYS_ECALL;
          else if (w[31:20] == 12'h001) sop = SYS_EBREAK;
          else if (w[31:20] == 12'h302) sop = SYS_MRET;
          else if (w[31:20] == 12'h7b2) sop = SYS_DRET;
          else if (w[31:20] == 12'h105) sop = SYS_WFI;
          else ill = 1'b1;
        end else if (f3 == 3'd4) begin
          ill = 1'b1;
        end else begin
          en = 6'b000100;
          imm = {20'd0, w[31:20]};
          wr = 1'b1;
          // A zero source turns set and clear into a plain read
          if (f3[1:0] == 2'd1) cop = CSR_OP_WRITE;
          else if (w[19:15] != 5'd0) cop = (f3[1:0] == 2'd2) ? CSR_OP_SET : CSR_OP_CLEAR;
        end
      end
      default: ill = 1'b1;
    endcase
    if (ill) begin
      en = 6'd0;
      cop = CSR_OP_READ;
      sop = SYS_NONE;
    end
    wr = wr && (w[11:7] != 5'd0) && !ill;
    return {en, wr, ill, aop, cop, sop, w[11:7], w[19:15], w[24:20], imm, pc};
  endfunction

  // Model step for the coming edge, taken at the falling edge when all inputs are settled
  always @(negedge clk) begin
    if (arst_n_i) begin
      m_stall = mex_valid && !ex_ready_i;
      m_idr = kill_i || (!halt_i && !m_stall);
      m_idv = mb_valid && !kill_i && !halt_i && !m_stall;
      exp_ex_valid = mex_valid;
      exp_buf_full = mb_valid;
      if (mex_valid && ex_ready_i && rec_q.size() > 0) exp_rec = rec_q.pop_front();
      if (m_idv) rec_q.push_back(ref_decode(mb_instr, mb_pc));
      mex_valid = m_idv || (m_stall && mex_valid);
      m_accept = instr_valid_i && (!mb_valid || m_idr);
      if (m_accept) begin
        mb_instr = instr_i;
        mb_pc = pc_i;
      end
      mb_valid = m_accept || (mb_valid && !m_idr);
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    names = '{"legal_decode", "illegal_clean", "one_hot", "halt", "kill", "back_pressure"};
    arst_n_i = 1'b0;
    instr_valid_i = 1'b0;
    instr_i = 32'd0;
    pc_i = 32'd0;
    halt_i = 1'b0;
    kill_i = 1'b0;
    ex_ready_i = 1'b1;
    mb_valid = 1'b0;
    mex_valid = 1'b0;
    exp_ex_valid = 1'b0;
    exp_buf_full = 1'b0;
    exp_rec = '0;
    rng = 32'h30db_8e41;
    next_pc = 32'h0000_1000;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    arst_n_i <= 1'b1;
    for (int c = 0; c < 4000; c++) begin
      @(posedge clk);
      rng = xorshift(rng);
      ra = rng;
      rng = xorshift(rng);
      rb = rng;
      instr_valid_i <= rb[31] | rb[30];
      instr_i <= make_instr(ra, rb);
      pc_i <= next_pc;
      halt_i <= (rb[29:27] == 3'd0);
      kill_i <= (rb[26:23] == 4'd0);
      ex_ready_i <= (rb[22:21] != 2'd0);
      next_pc = next_pc + 32'd4;
    end
    // Drain whatever is still in flight
    @(posedge clk);
    instr_valid_i <= 1'b0;
    halt_i <= 1'b0;
    kill_i <= 1'b0;
    ex_ready_i <= 1'b1;
    timed_out = 1'b1;
    for (int t = 0; t < 100; t++) begin
      @(posedge clk);
      if (rec_q.size() == 0 && !mb_valid && !mex_valid) begin
        timed_out = 1'b0;
        break;
      end
    end
    repeat (2) @(posedge clk);
    total_chk = 0;
    total_err = 0;
    if (timed_out) begin
      $display("Timeout while waiting for the pipeline to drain");
      total_err++;
    end
    for (int i = 0; i < 6; i++) begin
      $display("%s: %0d checks, %0d errors", names[i],
               i_id_stage_checker.chk_cnt[i], i_id_stage_checker.err_cnt[i]);
      if (i_id_stage_checker.chk_cnt[i] == 0) begin
        $display("Test %s was never exercised", names[i]);
        total_err++;
      end
      total_chk += i_id_stage_checker.chk_cnt[i];
      total_err += i_id_stage_checker.err_cnt[i];
    end
    $display("Tests: 6, checks: %0d, errors: %0d", total_chk, total_err);
    if (total_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+include
rtl/rvd_pkg.sv
rtl/decode_bus_if.sv
rtl/fetch_buffer.sv
rtl/instr_decoder.sv
rtl/id_ex_register.sv
rtl/id_stage_top.sv
verification/id_stage_checker.sv
verification/tb_id_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_id_stage
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
